// File: csma_ca.f
source/csma_pkg.sv
source/nav_tracker.sv
source/us_countdown.sv
source/backoff_lfsr.sv
source/backoff_fsm.sv
source/csma_ca.sv
dv/csma_ca_tb.sv

// File: dv/csma_ca_tb.sv
// CSMA/CA testbench, runs a table of frame and access cases and checks NAV and IFS timing
`timescale 1ns/10ps

module csma_ca_tb;

    localparam int num_cases  = 11;
    localparam int kind_high  = 0;
    localparam int kind_retry = 1;
    localparam int fcs_none   = 0;  // no frame before the access
    localparam int fcs_good   = 1;
    localparam int fcs_bad    = 2;
    localparam int slot_us    = 9;
    localparam int sifs_us    = 16;
    localparam logic [47:0] own_addr = 48'h02_11_22_33_44_55;

    logic clk, rstn, tsf_pulse_1m;
    logic pkt_header_valid, pkt_header_valid_strobe;
    logic [15:0] signal_len;
    logic fcs_in_strobe, fcs_valid, addr1_valid, fc_di_valid;
    logic [47:0] addr1, self_mac_addr;
    logic [1:0]  fc_type;
    logic [3:0]  fc_subtype;
    logic [15:0] duration;
    logic        ch_idle;
    logic [4:0]  slot_time;
    logic [6:0]  sifs_time;
    logic [3:0]  cw_exp_used;
    logic retrans_trigger, quit_retrans, high_trigger, reset_backoff;
    logic tx_bb_is_ongoing, ack_tx_flag;
    csma_pkg::nav_t nav_remaining;
    logic ch_idle_final, backoff_done;

    // case table
    int          kind_tab     [num_cases];
    int          fcs_tab      [num_cases];
    bit          match_tab    [num_cases];
    logic [15:0] dur_tab      [num_cases];
    int          cw_tab       [num_cases];
    int          busy_at_tab  [num_cases];  // idle pulses before going busy, -1 never
    int          busy_len_tab [num_cases];
    int          lo_tab       [num_cases];
    int          hi_tab       [num_cases];

    int     row = 0;
    bit     model_fcs_good = 1'b0;  // eifs out of reset
    integer seed = 32'hf5f1_bbf5;
    int     pulse_phase = 0;
    int     cycle_cnt = 0;

    csma_ca DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // one microsecond strobe every 4 cycles
    initial begin
        forever begin
            @(negedge clk);
            pulse_phase = (pulse_phase + 1) % 4;
            tsf_pulse_1m = (pulse_phase == 0);
        end
    end

    function automatic int difs_us();
        return sifs_us + 2 * slot_us;
    endfunction

    function automatic int eifs_us();
        return sifs_us + difs_us() + int'(csma_pkg::longest_ack_time);
    endfunction

    function automatic logic [15:0] rand_dur();
        return 16'd20 + 16'($random(seed) & 32'h7f);
    endfunction

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_eq(input string name, input int got, input int want);
        assert (got == want) else begin
            $display("MISMATCH time=%0t %s got %0d expected %0d", $time, name, got, want);
            stop_run();
        end
    endtask

    task automatic check_range(input string name, input int got, input int lo, input int hi);
        assert (got >= lo && got <= hi) else begin
            $display("MISMATCH time=%0t %s got %0d expected %0d..%0d", $time, name, got, lo, hi);
            stop_run();
        end
    endtask

    // reference model of the IFS choice and backoff bounds
    task automatic add_case(input int kind, input int fcs, input bit match, input logic [15:0] dur,
                            input int cw, input int busy_at, input int busy_len);
        int ifs;
        int max_slots;
        if (fcs != fcs_none) model_fcs_good = (fcs == fcs_good);
        ifs       = model_fcs_good ? difs_us() : eifs_us();
        max_slots = (1 << ((cw > 10) ? 10 : cw)) - 1;
        kind_tab[row]     = kind;
        fcs_tab[row]      = fcs;
        match_tab[row]    = match;
        dur_tab[row]      = dur;
        cw_tab[row]       = cw;
        busy_at_tab[row]  = busy_at;
        busy_len_tab[row] = busy_len;
        if (kind == kind_high) begin
            lo_tab[row] = ifs;  // counted from the last return to idle
            hi_tab[row] = ifs;
        end else begin
            lo_tab[row] = (busy_at > 0) ? 1 : ifs;  // may resume a frozen backoff
            hi_tab[row] = ifs + max_slots * slot_us;
        end
        row++;
    endtask

    task automatic build_table();
        add_case(kind_high,  fcs_none, 0, 16'd0,                0, -1, 0);
        add_case(kind_high,  fcs_good, 1, rand_dur(),           0, -1, 0);  // addressed to us
        add_case(kind_high,  fcs_bad,  0, rand_dur(),           0, -1, 0);
        add_case(kind_high,  fcs_good, 0, rand_dur(),           0, -1, 0);  // nav set
        add_case(kind_high,  fcs_good, 0, 16'h8000 | rand_dur(), 0, -1, 0);
        add_case(kind_retry, fcs_good, 0, rand_dur(),           0, -1, 0);
        add_case(kind_retry, fcs_none, 0, 16'd0,                4, -1, 0);
        add_case(kind_high,  fcs_none, 0, 16'd0,                0,  0, 5);  // busy at trigger
        add_case(kind_high,  fcs_bad,  1, rand_dur(),           0,  0, 3);
        add_case(kind_high,  fcs_good, 0, rand_dur(),           0, 10, 4);  // busy inside difs
        add_case(kind_retry, fcs_none, 0, 16'd0,  4, difs_us() + 2, 4);     // busy in backoff
    endtask

    task automatic init_inputs();
        rstn = 1'b0;
        tsf_pulse_1m = 1'b0;
        pkt_header_valid = 1'b0;
        pkt_header_valid_strobe = 1'b0;
        signal_len = 16'd20;
        fcs_in_strobe = 1'b0;
        fcs_valid = 1'b0;
        addr1_valid = 1'b0;
        addr1 = '0;
        self_mac_addr = own_addr;
        fc_di_valid = 1'b0;
        fc_type = csma_pkg::fc_type_ctrl;
        fc_subtype = 4'hb;  // rts
        duration = '0;
        ch_idle = 1'b1;
        slot_time = 5'(slot_us);
        sifs_time = 7'(sifs_us);
        cw_exp_used = '0;
        retrans_trigger = 1'b0;
        quit_retrans = 1'b0;
        high_trigger = 1'b0;
        reset_backoff = 1'b0;
        tx_bb_is_ongoing = 1'b0;
        ack_tx_flag = 1'b0;
    endtask

    // header, duration, addr1, fcs, then follow the nav down to zero
    task automatic send_frame(input int fcs, input bit match, input logic [15:0] dur);
        int nav_exp;
        bit p;
        @(negedge clk);
        pkt_header_valid_strobe = 1'b1;
        pkt_header_valid = 1'b1;
        @(negedge clk);
        pkt_header_valid_strobe = 1'b0;
        fc_di_valid = 1'b1;
        duration = dur;
        @(negedge clk);
        fc_di_valid = 1'b0;
        addr1_valid = 1'b1;
        addr1 = match ? own_addr : (own_addr ^ 48'h0000_0000_0f00);
        @(negedge clk);
        addr1_valid = 1'b0;
        fcs_in_strobe = 1'b1;
        fcs_valid = (fcs == fcs_good);
        @(negedge clk);
        fcs_in_strobe = 1'b0;
        nav_exp = (fcs == fcs_good && !match && !dur[15]) ? int'(dur[14:0]) : 0;
        check_eq("nav_remaining", nav_remaining, nav_exp);
        check_eq("ch_idle_final", ch_idle_final, nav_exp == 0);
        while (nav_exp != 0) begin
            @(posedge clk);
            p = tsf_pulse_1m;
            @(negedge clk);
            if (p) nav_exp--;
            check_eq("nav_remaining", nav_remaining, nav_exp);
            check_eq("ch_idle_final", ch_idle_final, nav_exp == 0);
        end
    endtask

    // trigger an access and count idle pulses until backoff_done
    task automatic run_access(input int kind, input int cw, input int busy_at, input int busy_len,
                              output int pulses);
        bit in_busy;
        bit busy_used;
        bit skip;
        bit p;
        int busy_left;
        @(negedge clk);
        cw_exp_used = 4'(cw);
        in_busy = (busy_at == 0);
        busy_used = in_busy;
        busy_left = busy_len;
        ch_idle = !in_busy;
        high_trigger = (kind == kind_high);
        retrans_trigger = (kind == kind_retry);
        skip = 1'b1;  // load edge, its pulse is not counted
        pulses = 0;
        forever begin
            @(posedge clk);
            p = tsf_pulse_1m;
            if (skip) skip = 1'b0;
            else if (p && !in_busy) pulses++;
            @(negedge clk);
            high_trigger = 1'b0;
            retrans_trigger = 1'b0;
            if (in_busy) begin
                check_eq("backoff_done", backoff_done, 0);
                if (p) busy_left--;
                if (busy_left <= 0) begin
                    in_busy = 1'b0;
                    ch_idle = 1'b1;
                    pulses = 0;
                    skip = 1'b1;
                end
            end else if (backoff_done) begin
                break;
            end else if (!busy_used && busy_at > 0 && pulses == busy_at) begin
                in_busy = 1'b1;
                busy_used = 1'b1;
                busy_left = busy_len;
                ch_idle = 1'b0;
            end
        end
    endtask

    task automatic own_tx_start();
        tx_bb_is_ongoing = 1'b1;
        ack_tx_flag = 1'b0;
        @(negedge clk);
        tx_bb_is_ongoing = 1'b0;
        check_eq("backoff_done", backoff_done, 0);
    endtask

    initial begin
        while (cycle_cnt < num_cases * 1000) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("ERROR: test table did not finish within %0d cycles", cycle_cnt);
        stop_run();
    end

    initial begin
        int pulses;
        init_inputs();
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_eq("backoff_done", backoff_done, 0);
        check_eq("nav_remaining", nav_remaining, 0);
        for (int i = 0; i < num_cases; i++) begin
            if (fcs_tab[i] != fcs_none) send_frame(fcs_tab[i], match_tab[i], dur_tab[i]);
            run_access(kind_tab[i], cw_tab[i], busy_at_tab[i], busy_len_tab[i], pulses);
            check_range("pulses_to_backoff_done", pulses, lo_tab[i], hi_tab[i]);
            own_tx_start();
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: source/backoff_fsm.sv
// medium access FSM, picks DIFS or EIFS and runs the random backoff that freezes while busy
`timescale 1ns/10ps

module backoff_fsm (
    input  logic               clk,
    input  logic               rstn,
    input  logic               reset_backoff,
    input  logic               ch_idle_final,
    input  logic               fcs_in_strobe,
    input  logic               fcs_valid,
    input  logic [4:0]         slot_time,
    input  logic [6:0]         sifs_time,
    input  logic               high_trigger,
    input  logic               quit_retrans,
    input  logic               retrans_trigger,
    input  logic               tx_bb_is_ongoing,
    input  logic               ack_tx_flag,
    input  logic               wait_zero,
    input  logic               backoff_zero,
    input  csma_pkg::slots_t   num_slots,
    input  csma_pkg::backoff_t backoff_count,
    output logic               wait_load,
    output csma_pkg::wait_t    wait_value,
    output logic               wait_run,
    output logic               backoff_load,
    output csma_pkg::backoff_t backoff_value,
    output logic               backoff_run,
    output logic               lfsr_advance,
    output logic               backoff_done
);

    csma_pkg::backoff_state_t state;
    csma_pkg::backoff_state_t state_nxt;
    logic                     last_fcs_valid;  // low selects eifs
    logic                     is_retrans;      // pending access needs a random backoff
    logic                     is_retrans_nxt;
    logic                     any_trigger;
    logic                     new_retrans;
    csma_pkg::wait_t          difs_time;
    csma_pkg::wait_t          eifs_time;
    csma_pkg::wait_t          ifs_time;
    csma_pkg::wait_t          quit_wait;  // leftover backoff, at most one ifs

    assign difs_time = csma_pkg::wait_t'(sifs_time) + csma_pkg::wait_t'(slot_time)
                     + csma_pkg::wait_t'(slot_time);
    assign eifs_time = csma_pkg::wait_t'(sifs_time) + difs_time + csma_pkg::longest_ack_time;
    assign ifs_time  = last_fcs_valid ? difs_time : eifs_time;
    assign quit_wait = (backoff_count > csma_pkg::backoff_t'(ifs_time))
                     ? ifs_time
                     : csma_pkg::wait_t'(backoff_count);

    assign any_trigger = high_trigger || quit_retrans || retrans_trigger;
    assign new_retrans = retrans_trigger && !high_trigger && !quit_retrans;

    // one fresh draw per retransmission
    assign lfsr_advance  = (state == csma_pkg::st_idle) && new_retrans;
    assign backoff_value = csma_pkg::backoff_t'(num_slots) * csma_pkg::backoff_t'(slot_time);
    assign wait_run      = (state == csma_pkg::st_wait_1) || (state == csma_pkg::st_wait_2);
    assign backoff_run   = (state == csma_pkg::st_run) && ch_idle_final;
    assign backoff_done  = (state == csma_pkg::st_wait_for_own);

    always_comb begin
        state_nxt      = state;
        is_retrans_nxt = is_retrans;
        wait_load      = 1'b0;
        wait_value     = ifs_time;
        backoff_load   = 1'b0;
        case (state)
            csma_pkg::st_idle: begin
                if (any_trigger) begin
                    is_retrans_nxt = new_retrans;
                    if (!ch_idle_final) begin
                        state_nxt = csma_pkg::st_ch_busy;
                    end else begin
                        wait_load = 1'b1;
                        state_nxt = new_retrans ? csma_pkg::st_wait_2 : csma_pkg::st_wait_1;
                    end
                end
            end
            csma_pkg::st_ch_busy: begin
                if (ch_idle_final) begin  // full ifs again once the medium frees
                    wait_load = 1'b1;
                    state_nxt = is_retrans ? csma_pkg::st_wait_2 : csma_pkg::st_wait_1;
                end
            end
            csma_pkg::st_wait_1: begin
                if (!ch_idle_final) begin
                    state_nxt = csma_pkg::st_ch_busy;
                end else if (wait_zero) begin
                    state_nxt = csma_pkg::st_wait_for_own;
                end
            end
            csma_pkg::st_wait_2: begin
                if (!ch_idle_final) begin
                    state_nxt = csma_pkg::st_ch_busy;
                end else if (quit_retrans) begin
                    is_retrans_nxt = 1'b0;  // finish the ifs, no backoff
                    state_nxt      = csma_pkg::st_wait_1;
                end else if (wait_zero) begin
                    backoff_load = 1'b1;
                    state_nxt    = csma_pkg::st_run;
                end
            end
            csma_pkg::st_run, csma_pkg::st_suspend: begin
                if (ch_idle_final && quit_retrans) begin
                    is_retrans_nxt = 1'b0;
                    wait_load      = 1'b1;
                    wait_value     = quit_wait;
                    state_nxt      = csma_pkg::st_wait_1;
                end else if (ch_idle_final) begin
                    if (state == csma_pkg::st_suspend) begin
                        state_nxt = csma_pkg::st_run;
                    end else if (backoff_zero) begin
                        state_nxt = csma_pkg::st_wait_for_own;
                    end
                end else if (state == csma_pkg::st_run) begin
                    // freeze the slot count, or start over if it was already spent
                    state_nxt = backoff_zero ? csma_pkg::st_ch_busy : csma_pkg::st_suspend;
                end else if (quit_retrans) begin
                    is_retrans_nxt = 1'b0;
                    state_nxt      = csma_pkg::st_ch_busy;
                end
            end
            csma_pkg::st_wait_for_own: begin
                if (tx_bb_is_ongoing) begin
                    is_retrans_nxt = ack_tx_flag;  // our ack goes out, then back off
                    state_nxt      = ack_tx_flag ? csma_pkg::st_ch_busy : csma_pkg::st_idle;
                end
            end
            default: begin
                state_nxt = csma_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn || reset_backoff) begin
            state      <= csma_pkg::st_idle;
            is_retrans <= 1'b0;
        end else begin
            state      <= state_nxt;
            is_retrans <= is_retrans_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            last_fcs_valid <= 1'b0;
        end else if (fcs_in_strobe) begin
            last_fcs_valid <= fcs_valid;
        end
    end

    // the slot count loads only at the end of the ifs and the backoff timer takes it
    assert property (@(posedge clk) disable iff (!rstn || reset_backoff)
        backoff_load |-> (state == csma_pkg::st_wait_2)
                         ##1 (backoff_count == $past(backoff_value)));

endmodule

// File: source/backoff_lfsr.sv
// 32-bit LFSR random source and slot draw masked by the contention window exponent
`timescale 1ns/10ps

module backoff_lfsr (
    input  logic             clk,
    input  logic             rstn,
    input  logic             advance,
    input  logic [3:0]       cw_exp_used,
    output csma_pkg::slots_t num_slots
);

    logic [31:0] lfsr;
    logic [3:0]  exp_clamped;
    logic [9:0]  cw_mask;  // 2^exp - 1

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lfsr <= csma_pkg::lfsr_seed;
        end else if (advance) begin
            lfsr <= {lfsr[30:0], ~^{lfsr[31], lfsr[21], lfsr[1:0]}};  // taps 32,22,2,1
        end
    end

    assign exp_clamped = (cw_exp_used > 4'(csma_pkg::cw_max)) ? 4'(csma_pkg::cw_max)
                                                              : cw_exp_used;
    assign cw_mask     = ~(10'h3ff << exp_clamped);
    assign num_slots   = lfsr[9:0] & cw_mask;

endmodule

// File: source/csma_ca.sv
// CSMA/CA channel access top, joins NAV tracking, IFS and backoff timers, LFSR and access FSM
`timescale 1ns/10ps

module csma_ca (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            tsf_pulse_1m,
    input  logic                            pkt_header_valid,
    input  logic                            pkt_header_valid_strobe,
    input  logic [15:0]                     signal_len,
    input  logic                            fcs_in_strobe,
    input  logic                            fcs_valid,
    input  logic                            addr1_valid,
    input  logic [csma_pkg::mac_addr_w-1:0] addr1,
    input  logic [csma_pkg::mac_addr_w-1:0] self_mac_addr,
    input  logic                            fc_di_valid,
    input  logic [1:0]                      fc_type,
    input  logic [3:0]                      fc_subtype,
    input  logic [15:0]                     duration,
    input  logic                            ch_idle,
    input  logic [4:0]                      slot_time,
    input  logic [6:0]                      sifs_time,
    input  logic [3:0]                      cw_exp_used,
    input  logic                            retrans_trigger,
    input  logic                            quit_retrans,
    input  logic                            high_trigger,
    input  logic                            reset_backoff,
    input  logic                            tx_bb_is_ongoing,
    input  logic                            ack_tx_flag,
    output csma_pkg::nav_t                  nav_remaining,
    output logic                            ch_idle_final,
    output logic                            backoff_done
);

    logic               nav_busy;
    logic               wait_load, wait_run, wait_zero;
    csma_pkg::wait_t    wait_value;
    logic               backoff_load, backoff_run, backoff_zero;
    csma_pkg::backoff_t backoff_value;
    csma_pkg::backoff_t backoff_count;
    logic               lfsr_advance;
    csma_pkg::slots_t   num_slots;

    assign ch_idle_final = ch_idle && !nav_busy;  // physical and virtual sense both idle

    nav_tracker nav_i (
        .clk, .rstn, .tsf_pulse_1m,
        .pkt_header_valid, .pkt_header_valid_strobe,
        .fcs_in_strobe, .fcs_valid,
        .addr1_valid, .addr1, .self_mac_addr,
        .fc_di_valid, .duration,
        .nav_remaining, .nav_busy
    );

    us_countdown #(.count_t(csma_pkg::wait_t)) wait_timer_i (
        .clk, .rstn, .tsf_pulse_1m,
        .load(wait_load), .load_value(wait_value), .run(wait_run),
        .count(), .zero(wait_zero)
    );

    us_countdown #(.count_t(csma_pkg::backoff_t)) backoff_timer_i (
        .clk, .rstn, .tsf_pulse_1m,
        .load(backoff_load), .load_value(backoff_value), .run(backoff_run),
        .count(backoff_count), .zero(backoff_zero)
    );

    backoff_lfsr lfsr_i (
        .clk, .rstn,
        .advance(lfsr_advance), .cw_exp_used, .num_slots
    );

    backoff_fsm fsm_i (
        .clk, .rstn, .reset_backoff, .ch_idle_final,
        .fcs_in_strobe, .fcs_valid, .slot_time, .sifs_time,
        .high_trigger, .quit_retrans, .retrans_trigger,
        .tx_bb_is_ongoing, .ack_tx_flag,
        .wait_zero, .backoff_zero, .num_slots, .backoff_count,
        .wait_load, .wait_value, .wait_run,
        .backoff_load, .backoff_value, .backoff_run,
        .lfsr_advance, .backoff_done
    );

endmodule

// File: source/csma_pkg.sv
// shared widths, state encodings and IFS constants for the CSMA/CA channel access unit
package csma_pkg;

    localparam int nav_w      = 15;
    localparam int mac_addr_w = 48;
    localparam int cw_max     = 10;  // larger exponents clamp here

    typedef logic [nav_w-1:0] nav_t;
    typedef logic [11:0]      wait_t;     // ifs wait in microseconds
    typedef logic [12:0]      backoff_t;  // backoff in microseconds
    typedef logic [9:0]       slots_t;

    localparam wait_t       longest_ack_time = 12'd44;  // extra microseconds for eifs
    localparam logic [31:0] lfsr_seed        = 32'h1020_f0cb;

    localparam logic [1:0] fc_type_ctrl = 2'b01;  // control frame type

    typedef enum logic [1:0] {
        nav_idle              = 2'd0,
        nav_wait_for_duration = 2'd1,
        nav_check_ra          = 2'd2,
        nav_update            = 2'd3
    } nav_state_t;

    typedef enum logic [2:0] {
        st_idle         = 3'd0,
        st_ch_busy      = 3'd1,
        st_wait_1       = 3'd2,  // ifs only
        st_wait_2       = 3'd3,  // ifs then random backoff
        st_run          = 3'd4,
        st_suspend      = 3'd5,
        st_wait_for_own = 3'd6
    } backoff_state_t;

endpackage

// File: source/nav_tracker.sv
// virtual carrier sense, parses received headers and keeps the NAV counting down per microsecond
`timescale 1ns/10ps

module nav_tracker (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            tsf_pulse_1m,
    input  logic                            pkt_header_valid,
    input  logic                            pkt_header_valid_strobe,
    input  logic                            fcs_in_strobe,
    input  logic                            fcs_valid,
    input  logic                            addr1_valid,
    input  logic [csma_pkg::mac_addr_w-1:0] addr1,
    input  logic [csma_pkg::mac_addr_w-1:0] self_mac_addr,
    input  logic                            fc_di_valid,
    input  logic [15:0]                     duration,
    output csma_pkg::nav_t                  nav_remaining,
    output logic                            nav_busy
);

    csma_pkg::nav_state_t nav_state;
    csma_pkg::nav_t       nav_new;  // duration of the frame being parsed
    logic                 dur_ok;
    logic                 nav_set;

    assign dur_ok   = fc_di_valid && !duration[15];  // bit 15 set is not a duration
    assign nav_set  = (nav_state == csma_pkg::nav_update) && fcs_in_strobe && fcs_valid;
    assign nav_busy = (nav_remaining != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            nav_state <= csma_pkg::nav_idle;
        end else if (pkt_header_valid_strobe) begin
            // each header restarts the parser, also recovers a frame that never saw its fcs
            if (pkt_header_valid) begin
                nav_state <= csma_pkg::nav_wait_for_duration;
            end else begin
                nav_state <= csma_pkg::nav_idle;
            end
        end else begin
            case (nav_state)
                csma_pkg::nav_wait_for_duration: begin
                    if (dur_ok) begin
                        nav_state <= csma_pkg::nav_check_ra;
                    end
                end
                csma_pkg::nav_check_ra: begin
                    // frames addressed to us leave the nav alone
                    if (addr1_valid && (addr1 != self_mac_addr)) begin
                        nav_state <= csma_pkg::nav_update;
                    end
                end
                csma_pkg::nav_update: begin
                    if (fcs_in_strobe) begin
                        nav_state <= csma_pkg::nav_idle;
                    end
                end
                default: begin
                    nav_state <= nav_state;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((nav_state == csma_pkg::nav_wait_for_duration) && dur_ok) begin
            nav_new <= duration[csma_pkg::nav_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            nav_remaining <= '0;
        end else if (nav_set) begin
            // keep the longer reservation
            nav_remaining <= (nav_new > nav_remaining) ? nav_new : nav_remaining;
        end else if (tsf_pulse_1m && nav_busy) begin
            nav_remaining <= nav_remaining - 1'b1;
        end
    end

    // the nav only grows through a confirmed frame
    assert property (@(posedge clk) disable iff (!rstn)
        (nav_remaining > $past(nav_remaining)) |-> $past(nav_set));

endmodule

// File: source/us_countdown.sv
// loadable microsecond down-counter, paused by run and stepped by the 1 MHz pulse
`timescale 1ns/10ps

module us_countdown #(
    parameter type count_t = logic [7:0]
) (
    input  logic   clk,
    input  logic   rstn,
    input  logic   tsf_pulse_1m,
    input  logic   load,
    input  count_t load_value,
    input  logic   run,
    output count_t count,
    output logic   zero
);

    assign zero = (count == '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;  // load wins over a same-cycle pulse
        end else if (run && tsf_pulse_1m && !zero) begin
            count <= count - 1'b1;
        end
    end

    // the count only rises through a load and never wraps from zero
    assert property (@(posedge clk) disable iff (!rstn)
        !load |=> (count <= $past(count)));

endmodule
